// File: frame_pkg.sv
// Shared constants, bit positions and packed types of the board-control block.
// The RTL and the testbench refer to everything here with frame_pkg:: scoped names.
// Game-side settings (buttons, polarity, DIP base) are fixed per core in this package.

`default_nettype none

package frame_pkg;

    // Core configuration
    localparam int DIPBASE                = 16;
    localparam int BUTTONS                = 2;
    localparam bit GAME_INPUTS_ACTIVE_LOW = 1'b1;
    localparam int JOY_W                  = 10;

    // Game reset hold and LED blink
    localparam int RST_HOLD  = 16;
    localparam int RST_CNT_W = $clog2(RST_HOLD + 1);
    localparam int BLINK_W   = 4;

    // Status word bit positions
    localparam int ST_TEST  = 1;
    localparam int ST_PAUSE = 2;
    localparam int ST_FLIP  = 3;
    localparam int ST_FX    = 4;  // two bits
    localparam int ST_FM_N  = 6;
    localparam int ST_PSG_N = 7;
    localparam int ST_ROT   = 8;  // two bits

    // Raw board joystick layout
    localparam int JB_DIR     = 0;   // up, down, left, right
    localparam int JB_DIR_W   = 4;
    localparam int JB_BTN     = 4;   // buttons 1 to 6
    localparam int JB_BTN_W   = 6;
    localparam int JB_START   = 10;
    localparam int JB_COIN    = 11;
    localparam int JB_SERVICE = 12;

    // Directions plus the buttons the game really uses
    localparam logic [JOY_W-1:0] JOY_MASK = JOY_W'((1 << (JB_DIR_W + BUTTONS)) - 1);

    typedef logic [31:0] status_t;

    typedef struct packed {
        logic [15:0] joy1;
        logic [15:0] joy2;
        logic [15:0] joy3;
        logic [15:0] joy4;
    } board_joy_t;

    typedef struct packed {
        logic        dip_test;
        logic        dip_pause;
        logic        dip_flip;
        logic [1:0]  dip_fxlevel;
        logic        enable_fm;
        logic        enable_psg;
        logic [1:0]  rotate;
        logic [15:0] dipsw;
    } dip_cfg_t;

    typedef struct packed {
        logic [JOY_W-1:0] joystick1;
        logic [JOY_W-1:0] joystick2;
        logic [JOY_W-1:0] joystick3;
        logic [JOY_W-1:0] joystick4;
        logic [3:0]       coin;
        logic [3:0]       start;
        logic             service;
    } game_inputs_t;

    // Reset values of the synchronized words and of the game inputs
    localparam status_t    STATUS_RST    = '0;
    localparam board_joy_t BOARD_JOY_RST = '0;
    localparam game_inputs_t GAME_IN_IDLE =
        {$bits(game_inputs_t){GAME_INPUTS_ACTIVE_LOW}};

endpackage

`default_nettype wire

// File: frame_sync.sv
// Two-flop synchronizer for quasi-static multi-bit levels coming from the
// I/O microcontroller domain. The payload type and its reset value are set
// per instance; bits may settle a cycle apart, which the slow sources allow.

`timescale 1ns/10ps
`default_nettype none

module frame_sync #(
    parameter type T       = frame_pkg::status_t,
    parameter T    RST_VAL = frame_pkg::STATUS_RST
) (
    input  logic clk_sys,
    input  logic rst_n,
    input  T     din,
    output T     dout
);

    T meta;

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            meta <= RST_VAL;
            dout <= RST_VAL;
        end else begin
            meta <= din;
            dout <= meta;
        end
    end

endmodule

`default_nettype wire

// File: frame_dip_decode.sv
// Decodes the synchronized status word into the DIP and OSD settings.
// All fields are registered once. flip_chg marks the cycle in which the
// registered flip setting takes a new value, so the game can be reset.

`timescale 1ns/10ps
`default_nettype none

module frame_dip_decode (
    input  logic               clk_sys,
    input  logic               rst_n,
    input  frame_pkg::status_t status_s,
    output frame_pkg::dip_cfg_t dip,
    output logic               flip_chg
);

    frame_pkg::dip_cfg_t dip_d;

    always_comb begin
        dip_d.dip_test    = status_s[frame_pkg::ST_TEST];
        dip_d.dip_pause   = status_s[frame_pkg::ST_PAUSE];
        dip_d.dip_flip    = status_s[frame_pkg::ST_FLIP];
        dip_d.dip_fxlevel = status_s[frame_pkg::ST_FX +: 2];
        // OSD bits are "disable" flags, so all zero means both chips on
        dip_d.enable_fm   = ~status_s[frame_pkg::ST_FM_N];
        dip_d.enable_psg  = ~status_s[frame_pkg::ST_PSG_N];
        dip_d.rotate      = status_s[frame_pkg::ST_ROT +: 2];
        dip_d.dipsw       = status_s[frame_pkg::DIPBASE +: 16];
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            dip      <= '0;
            flip_chg <= 1'b0;
        end else begin
            dip      <= dip_d;
            // High together with the new dip_flip value
            flip_chg <= dip_d.dip_flip ^ dip.dip_flip;
        end
    end

endmodule

`default_nettype wire

// File: frame_joy_map.sv
// Maps the four raw board joysticks onto the game-side inputs.
// Each game joystick carries the buttons above the four directions, with
// unused buttons held inactive. Coin, start and service are gathered from
// their own raw bits. Everything uses the game polarity and is registered once.

`timescale 1ns/10ps
`default_nettype none

module frame_joy_map (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    input  frame_pkg::board_joy_t   joy_s,
    output frame_pkg::game_inputs_t game_in
);

    frame_pkg::game_inputs_t game_in_d;

    // Raw joystick to game joystick, before polarity
    function automatic logic [frame_pkg::JOY_W-1:0] map_joy(input logic [15:0] raw);
        logic [frame_pkg::JOY_W-1:0] act;
        act = {raw[frame_pkg::JB_BTN +: frame_pkg::JB_BTN_W],
               raw[frame_pkg::JB_DIR +: frame_pkg::JB_DIR_W]};
        return act & frame_pkg::JOY_MASK;
    endfunction

    always_comb begin
        game_in_d.joystick1 = map_joy(joy_s.joy1)
                              ^ {frame_pkg::JOY_W{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};
        game_in_d.joystick2 = map_joy(joy_s.joy2)
                              ^ {frame_pkg::JOY_W{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};
        game_in_d.joystick3 = map_joy(joy_s.joy3)
                              ^ {frame_pkg::JOY_W{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};
        game_in_d.joystick4 = map_joy(joy_s.joy4)
                              ^ {frame_pkg::JOY_W{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};

        // Player 1 on bit 0
        game_in_d.coin = {joy_s.joy4[frame_pkg::JB_COIN],
                          joy_s.joy3[frame_pkg::JB_COIN],
                          joy_s.joy2[frame_pkg::JB_COIN],
                          joy_s.joy1[frame_pkg::JB_COIN]}
                         ^ {4{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};

        game_in_d.start = {joy_s.joy4[frame_pkg::JB_START],
                           joy_s.joy3[frame_pkg::JB_START],
                           joy_s.joy2[frame_pkg::JB_START],
                           joy_s.joy1[frame_pkg::JB_START]}
                          ^ {4{frame_pkg::GAME_INPUTS_ACTIVE_LOW}};

        // Only the first joystick has a service button
        game_in_d.service = joy_s.joy1[frame_pkg::JB_SERVICE]
                            ^ frame_pkg::GAME_INPUTS_ACTIVE_LOW;
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            game_in <= frame_pkg::GAME_IN_IDLE;
        end else begin
            game_in <= game_in_d;
        end
    end

endmodule

`default_nettype wire

// File: frame_reset.sv
// Game reset sequencer. Any cause (system reset, reset request, download
// or a flip change) reloads the hold counter. game_rst_n rises once the
// counter has run down to zero with no cause left, i.e. it stays low for
// RST_HOLD cycles after the last cause.

`timescale 1ns/10ps
`default_nettype none

module frame_reset (
    input  logic clk_sys,
    input  logic rst_n,
    input  logic rst_req,
    input  logic downloading,
    input  logic flip_chg,
    output logic game_rst_n
);

    logic                           cause;
    logic [frame_pkg::RST_CNT_W-1:0] hold_cnt;

    assign cause = rst_req | downloading | flip_chg;

    // System reset loads the counter, so the game comes up held
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hold_cnt <= frame_pkg::RST_CNT_W'(frame_pkg::RST_HOLD);
        end else if (cause) begin
            hold_cnt <= frame_pkg::RST_CNT_W'(frame_pkg::RST_HOLD);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    // Cause acts in its own cycle
    assign game_rst_n = (hold_cnt == '0) && !cause;

endmodule

`default_nettype wire

// File: frame_led.sv
// Board LED driver. Normally shows the game LED, inverted while the OSD is
// open. During a ROM download the LED blinks from a small free-running
// counter instead.

`timescale 1ns/10ps
`default_nettype none

module frame_led (
    input  logic       clk_sys,
    input  logic       rst_n,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    logic [frame_pkg::BLINK_W-1:0] blink_cnt;

    // Restarts from zero at every download
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            blink_cnt <= '0;
        end else if (downloading) begin
            blink_cnt <= blink_cnt + 1'b1;
        end else begin
            blink_cnt <= '0;
        end
    end

    // game_led[1] is for boards with a second LED; this board has one
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            led <= 1'b0;
        end else if (downloading) begin
            led <= blink_cnt[frame_pkg::BLINK_W-1];
        end else begin
            led <= game_led[0] ^ osd_shown;
        end
    end

endmodule

`default_nettype wire

// File: frame_board.sv
// Top of the board-control block. Brings the status word and the raw
// joysticks into clk_sys, decodes the DIP/OSD settings, maps the game
// inputs, sequences the game reset and drives the board LED.
// status and board_joy may come from any clock; the rest is on clk_sys.

`timescale 1ns/10ps
`default_nettype none

module frame_board (
    input  logic                    clk_sys,
    input  logic                    rst_n,
    // From the I/O microcontroller
    input  frame_pkg::status_t      status,
    input  frame_pkg::board_joy_t   board_joy,
    // Reset and LED sources
    input  logic                    rst_req,
    input  logic                    downloading,
    input  logic                    osd_shown,
    input  logic [1:0]              game_led,
    // To the game
    output frame_pkg::dip_cfg_t     dip,
    output frame_pkg::game_inputs_t game_in,
    output logic                    game_rst_n,
    output logic                    led
);

    frame_pkg::status_t    status_s;
    frame_pkg::board_joy_t joy_s;
    logic                  flip_chg;

    frame_sync #(
        .T       ( frame_pkg::status_t   ),
        .RST_VAL ( frame_pkg::STATUS_RST )
    ) u_status_sync (
        .clk_sys ( clk_sys  ),
        .rst_n   ( rst_n    ),
        .din     ( status   ),
        .dout    ( status_s )
    );

    frame_sync #(
        .T       ( frame_pkg::board_joy_t   ),
        .RST_VAL ( frame_pkg::BOARD_JOY_RST )
    ) u_joy_sync (
        .clk_sys ( clk_sys   ),
        .rst_n   ( rst_n     ),
        .din     ( board_joy ),
        .dout    ( joy_s     )
    );

    frame_dip_decode u_dip_decode (
        .clk_sys  ( clk_sys  ),
        .rst_n    ( rst_n    ),
        .status_s ( status_s ),
        .dip      ( dip      ),
        .flip_chg ( flip_chg )
    );

    frame_joy_map u_joy_map (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .joy_s   ( joy_s   ),
        .game_in ( game_in )
    );

    frame_reset u_reset (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .flip_chg    ( flip_chg    ),
        .game_rst_n  ( game_rst_n  )
    );

    frame_led u_led (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .led         ( led         )
    );

endmodule

`default_nettype wire

// File: frame_board_properties.sv
// Concurrent checks on the board-control block, bound into frame_board.
// Covers the flip change pulse, the game reset causes and the LED reset.

`timescale 1ns/10ps
`default_nettype none

module frame_board_properties (
    input logic clk_sys,
    input logic rst_n,
    input logic rst_req,
    input logic downloading,
    input logic flip_chg,
    input logic game_rst_n,
    input logic led
);

    // A flip change is a single-cycle pulse
    a_flip_pulse: assert property (
        @(posedge clk_sys) disable iff (!rst_n) flip_chg |=> !flip_chg
    ) else $error("flip_chg stayed high for two cycles");

    a_rst_cause: assert property (
        @(posedge clk_sys) disable iff (!rst_n) (rst_req || downloading) |-> !game_rst_n
    ) else $error("game_rst_n high while a reset cause is present");

    a_led_reset: assert property (
        @(posedge clk_sys) !rst_n |-> !led
    ) else $error("led not cleared during system reset");

endmodule

bind frame_board frame_board_properties u_props (
    .clk_sys     ( clk_sys     ),
    .rst_n       ( rst_n       ),
    .rst_req     ( rst_req     ),
    .downloading ( downloading ),
    .flip_chg    ( flip_chg    ),
    .game_rst_n  ( game_rst_n  ),
    .led         ( led         )
);

`default_nettype wire

// File: tb_frame_board.sv
// Directed testbench for the board-control block.
// Each test task drives frame_board on the falling clock edge and checks
// dip, game_in, game_rst_n and led against reference models of the rules.
// Run through list.f; the assertion module is bound in separately.

`timescale 1ns/10ps
`default_nettype none

module tb_frame_board;

    localparam int N_STATUS  = 12;
    localparam int N_JOY     = 12;
    localparam int DL_CYCLES = 10;
    localparam int SETTLE    = frame_pkg::RST_HOLD + 6;
    localparam int BLINK_LEN = 32;
    // Sum of the test lengths plus a margin
    localparam int CYCLE_LIMIT = (3 + frame_pkg::RST_HOLD) + 3 * (N_STATUS + N_JOY)
        + SETTLE + (1 + frame_pkg::RST_HOLD) + (DL_CYCLES + frame_pkg::RST_HOLD)
        + (4 + frame_pkg::RST_HOLD + 6) + (4 + BLINK_LEN + frame_pkg::RST_HOLD) + 50;

    logic                    clk_sys;
    logic                    rst_n;
    frame_pkg::status_t      status;
    frame_pkg::board_joy_t   board_joy;
    logic                    rst_req;
    logic                    downloading;
    logic                    osd_shown;
    logic [1:0]              game_led;
    frame_pkg::dip_cfg_t     dip;
    frame_pkg::game_inputs_t game_in;
    logic                    game_rst_n;
    logic                    led;

    int                      seed;
    int                      cycles = 0;
    frame_pkg::status_t      cur_status;
    frame_pkg::board_joy_t   cur_joy;

    frame_board dut0 (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .status      ( status      ),
        .board_joy   ( board_joy   ),
        .rst_req     ( rst_req     ),
        .downloading ( downloading ),
        .osd_shown   ( osd_shown   ),
        .game_led    ( game_led    ),
        .dip         ( dip         ),
        .game_in     ( game_in     ),
        .game_rst_n  ( game_rst_n  ),
        .led         ( led         )
    );

    initial begin
        clk_sys = 1'b0;
        forever #10 clk_sys = ~clk_sys;
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the tests ran past %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // Reference model of the status decode
    function automatic frame_pkg::dip_cfg_t exp_dip(input frame_pkg::status_t s);
        frame_pkg::dip_cfg_t d;
        d.dip_test    = s[frame_pkg::ST_TEST];
        d.dip_pause   = s[frame_pkg::ST_PAUSE];
        d.dip_flip    = s[frame_pkg::ST_FLIP];
        d.dip_fxlevel = s[frame_pkg::ST_FX +: 2];
        d.enable_fm   = !s[frame_pkg::ST_FM_N];
        d.enable_psg  = !s[frame_pkg::ST_PSG_N];
        d.rotate      = s[frame_pkg::ST_ROT +: 2];
        d.dipsw       = s[frame_pkg::DIPBASE +: 16];
        return d;
    endfunction

    // Directions in 3:0, buttons 1 to 6 in 9:4
    function automatic logic [frame_pkg::JOY_W-1:0] exp_joy(input logic [15:0] raw);
        logic [frame_pkg::JOY_W-1:0] j;
        int                          b;
        j = raw[frame_pkg::JOY_W-1:0];
        for (b = frame_pkg::BUTTONS; b < 6; b++) begin
            j[4 + b] = 1'b0;
        end
        if (frame_pkg::GAME_INPUTS_ACTIVE_LOW) begin
            j = ~j;
        end
        return j;
    endfunction

    function automatic frame_pkg::game_inputs_t exp_inputs(input frame_pkg::board_joy_t bj);
        frame_pkg::game_inputs_t g;
        g.joystick1 = exp_joy(bj.joy1);
        g.joystick2 = exp_joy(bj.joy2);
        g.joystick3 = exp_joy(bj.joy3);
        g.joystick4 = exp_joy(bj.joy4);
        g.coin      = {bj.joy4[11], bj.joy3[11], bj.joy2[11], bj.joy1[11]};
        g.start     = {bj.joy4[10], bj.joy3[10], bj.joy2[10], bj.joy1[10]};
        g.service   = bj.joy1[12];
        if (frame_pkg::GAME_INPUTS_ACTIVE_LOW) begin
            g.coin    = ~g.coin;
            g.start   = ~g.start;
            g.service = ~g.service;
        end
        return g;
    endfunction

    task automatic check_dip(input frame_pkg::dip_cfg_t exp);
        if (dip !== exp) begin
            $display("FAILED dip: expected %h, got %h", exp, dip);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_inputs(input frame_pkg::game_inputs_t exp);
        if (game_in !== exp) begin
            $display("FAILED game_in: expected %h, got %h", exp, game_in);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, got);
            $display("Test failed");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // Cause was removed on the last falling edge
    task automatic check_release();
        int i;
        for (i = 1; i <= frame_pkg::RST_HOLD; i++) begin
            @(negedge clk_sys);
            check_bit("game_rst_n", game_rst_n, i == frame_pkg::RST_HOLD);
        end
    endtask

    task automatic let_reset_expire();
        repeat (SETTLE) @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b1);
    endtask

    task automatic test_reset_values();
        frame_pkg::game_inputs_t idle;
        idle = frame_pkg::GAME_INPUTS_ACTIVE_LOW ? '1 : '0;
        rst_n = 1'b0;
        repeat (3) @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        check_bit("led", led, 1'b0);
        check_dip('0);
        check_inputs(idle);
        rst_n = 1'b1;
        check_release();
    endtask

    task automatic test_status_decode();
        frame_pkg::status_t s;
        int                 n;
        for (n = 0; n < N_STATUS; n++) begin
            s = $random(seed);
            status = s;
            repeat (2) @(negedge clk_sys);
            check_dip(exp_dip(cur_status));
            @(negedge clk_sys);
            check_dip(exp_dip(s));
            cur_status = s;
        end
    endtask

    task automatic test_joy_map();
        frame_pkg::board_joy_t bj;
        int                    n;
        for (n = 0; n < N_JOY; n++) begin
            bj = {$random(seed), $random(seed)};
            board_joy = bj;
            repeat (2) @(negedge clk_sys);
            check_inputs(exp_inputs(cur_joy));
            @(negedge clk_sys);
            check_inputs(exp_inputs(bj));
            cur_joy = bj;
        end
    endtask

    task automatic test_reset_causes();
        let_reset_expire();
        rst_req = 1'b1;
        @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        rst_req = 1'b0;
        check_release();
        downloading = 1'b1;
        repeat (DL_CYCLES) begin
            @(negedge clk_sys);
            check_bit("game_rst_n", game_rst_n, 1'b0);
        end
        downloading = 1'b0;
        check_release();
    endtask

    task automatic test_flip_reset();
        frame_pkg::status_t s;
        s = cur_status;
        s[frame_pkg::ST_FLIP] = ~s[frame_pkg::ST_FLIP];
        status = s;
        repeat (2) begin
            @(negedge clk_sys);
            check_bit("game_rst_n", game_rst_n, 1'b1);
        end
        @(negedge clk_sys);
        check_dip(exp_dip(s));
        check_bit("game_rst_n", game_rst_n, 1'b0);
        @(negedge clk_sys);
        check_bit("game_rst_n", game_rst_n, 1'b0);
        check_release();
        cur_status = s;
        // Every bit but flip changes, no reset expected
        s = ~cur_status;
        s[frame_pkg::ST_FLIP] = cur_status[frame_pkg::ST_FLIP];
        status = s;
        repeat (6) begin
            @(negedge clk_sys);
            check_bit("game_rst_n", game_rst_n, 1'b1);
        end
        check_dip(exp_dip(s));
        cur_status = s;
    endtask

    task automatic test_led();
        int         k;
        int         blk;
        logic [1:0] combo;
        for (k = 0; k < 4; k++) begin
            combo = k[1:0];
            game_led  = {$random(seed) % 2 != 0, combo[0]};
            osd_shown = combo[1];
            @(negedge clk_sys);
            check_bit("led", led, combo[0] ^ combo[1]);
        end
        downloading = 1'b1;
        for (k = 1; k <= BLINK_LEN; k++) begin
            @(negedge clk_sys);
            blk = (k - 1) >> (frame_pkg::BLINK_W - 1);
            check_bit("led", led, blk[0]);
        end
        downloading = 1'b0;
        check_release();
    endtask

    initial begin
        seed        = 9;
        rst_n       = 1'b0;
        status      = '0;
        board_joy   = '0;
        rst_req     = 1'b0;
        downloading = 1'b0;
        osd_shown   = 1'b0;
        game_led    = 2'b00;
        cur_status  = '0;
        cur_joy     = '0;
        test_reset_values();
        test_status_decode();
        test_joy_map();
        test_reset_causes();
        test_flip_reset();
        test_led();
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
frame_pkg.sv
frame_sync.sv
frame_dip_decode.sv
frame_joy_map.sv
frame_reset.sv
frame_led.sv
frame_board.sv
frame_board_properties.sv
tb_frame_board.sv

// File: Makefile
# Verilator build and run of the board-control testbench

VERILATOR ?= verilator
TOP       ?= tb_frame_board
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --assert -j $(JOBS)
PASS_TEXT ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
